/* include/music_settings.svh */
`ifndef MUSIC_SETTINGS_SVH
`define MUSIC_SETTINGS_SVH

// index bits within one song
`define SONG_WIDTH 5

`define NOTE_WIDTH 6
`define DURATION_WIDTH 6
`define VOICE_SEL_WIDTH 1

// signed output of one voice
`define SAMPLE_WIDTH 16

// square wave level, both polarities
`define AMPLITUDE 8192

// clock cycles per beat
`define BEAT_TICKS 16

`define ROM_WORD_WIDTH 16

`endif

/* rtl/music_pkg.sv */
`include "music_settings.svh"

package music_pkg;

    // note entry layout
    typedef struct packed {
        logic                          is_wait;
        logic [`NOTE_WIDTH-1:0]        note;
        logic [`DURATION_WIDTH-1:0]    duration;
        logic [`VOICE_SEL_WIDTH-1:0]   voice;
        logic [`ROM_WORD_WIDTH-`NOTE_WIDTH-`DURATION_WIDTH-`VOICE_SEL_WIDTH-2:0] spare;
    } note_view_t;

    // wait entry layout
    typedef struct packed {
        logic                                      is_wait;
        logic [`ROM_WORD_WIDTH-`DURATION_WIDTH-2:0] unused;
        logic [`DURATION_WIDTH-1:0]                wait_beats;
    } wait_view_t;

    // bit 15 tells which view is valid
    typedef union packed {
        note_view_t note_view;
        wait_view_t wait_view;
    } song_word_u;

    typedef enum logic [2:0] {
        PAUSED   = 3'b000,
        WAIT     = 3'b001,
        ADVANCE  = 3'b010,
        RETRIEVE = 3'b011,
        DISPATCH = 3'b100
    } reader_state_e;

endpackage

/* rtl/song_rom.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module song_rom
    import music_pkg::*;
(
    input  logic                         clk,
    input  logic [`SONG_WIDTH+1:0]       rom_addr,
    output logic [`ROM_WORD_WIDTH-1:0]   rom_word
);

    localparam int NOTE_W = `NOTE_WIDTH;
    localparam int DUR_W = `DURATION_WIDTH;

    logic [`SONG_WIDTH+1:0] addr_q;
    logic [1:0]             sel;
    logic [`SONG_WIDTH-1:0] idx;
    logic [7:0]             pitch_sum;
    logic [7:0]             pitch_mod;
    logic [2:0]             dur_mod;
    logic [1:0]             beat_mod;
    song_word_u             entry;

    // one cycle of latency
    always_ff @(posedge clk) begin
        addr_q <= rom_addr;
    end

    assign sel = addr_q[`SONG_WIDTH+1:`SONG_WIDTH];
    assign idx = addr_q[`SONG_WIDTH-1:0];

    // contents follow from song and index
    always_comb begin
        pitch_sum = 8'd7 * 8'(sel) + 8'd5 * 8'(idx);
        pitch_mod = pitch_sum % 8'd62;
        dur_mod = 3'(idx % 5);
        beat_mod = 2'(idx % 3);
        entry = '0;
        if (idx[1:0] == 2'b11) begin
            entry.wait_view.is_wait = 1'b1;
            entry.wait_view.wait_beats = DUR_W'(beat_mod) + 1'b1;
        end else begin
            entry.note_view.is_wait = 1'b0;
            entry.note_view.note = NOTE_W'(pitch_mod + 8'd1);
            entry.note_view.duration = DUR_W'(dur_mod) + 1'b1;
            // odd entries go to voice b
            entry.note_view.voice = idx[0];
        end
    end

    assign rom_word = entry;

endmodule

/* rtl/song_reader.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module song_reader
    import music_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          play,
    input  logic [1:0]                    song,
    input  logic [`ROM_WORD_WIDTH-1:0]    rom_word,
    output logic [`SONG_WIDTH+1:0]        rom_addr,
    output logic [`NOTE_WIDTH-1:0]        note,
    output logic [`DURATION_WIDTH-1:0]    duration,
    output logic                          load_a,
    output logic                          load_b,
    output logic                          song_done,
    output reader_state_e                 state
);

    localparam int TICK_WIDTH = $clog2(`BEAT_TICKS);
    localparam logic [TICK_WIDTH-1:0] LAST_TICK = TICK_WIDTH'(`BEAT_TICKS - 1);

    reader_state_e                next_state;
    logic [`SONG_WIDTH-1:0]       index;
    logic [`DURATION_WIDTH-1:0]   beats_left;
    logic [TICK_WIDTH-1:0]        tick;
    song_word_u                   entry;
    logic                         last_index;
    logic                         wait_over;
    logic                         dispatch_note;

    // song is picked up by the ROM address register in RETRIEVE
    assign rom_addr = {song, index};
    assign entry = rom_word;

    assign last_index = (index == {`SONG_WIDTH{1'b1}});
    assign wait_over = (beats_left <= 1) && (tick == LAST_TICK);

    always_comb begin
        next_state = state;
        case (state)
            PAUSED: begin
                next_state = play ? RETRIEVE : PAUSED;
            end
            RETRIEVE: begin
                next_state = play ? DISPATCH : PAUSED;
            end
            DISPATCH: begin
                if (!play) begin
                    next_state = PAUSED;
                end else if (entry.note_view.is_wait) begin
                    next_state = WAIT;
                end else begin
                    next_state = ADVANCE;
                end
            end
            WAIT: begin
                if (!play) begin
                    next_state = PAUSED;
                end else if (wait_over) begin
                    next_state = ADVANCE;
                end
            end
            ADVANCE: begin
                next_state = (play && !last_index) ? RETRIEVE : PAUSED;
            end
            default: begin
                next_state = PAUSED;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PAUSED;
            index <= '0;
            beats_left <= '0;
            tick <= '0;
        end else begin
            state <= next_state;
            // entry is complete once here, so step even if play dropped
            // (index 31 wraps to 0 for the next song)
            if (state == ADVANCE) begin
                index <= index + 1'b1;
            end
            if (state == DISPATCH) begin
                beats_left <= entry.wait_view.wait_beats;
                tick <= '0;
            end else if (state == WAIT) begin
                if (tick == LAST_TICK) begin
                    tick <= '0;
                    beats_left <= beats_left - 1'b1;
                end else begin
                    tick <= tick + 1'b1;
                end
            end
        end
    end

    // no load when play drops in DISPATCH, entry is fetched again on resume
    assign dispatch_note = (state == DISPATCH) && play && !entry.note_view.is_wait;
    assign load_a = dispatch_note && (entry.note_view.voice == '0);
    assign load_b = dispatch_note && (entry.note_view.voice != '0);

    assign note = entry.note_view.note;
    assign duration = entry.note_view.duration;

    assign song_done = (state == ADVANCE) && last_index;

endmodule

/* rtl/voice_player.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module voice_player (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load,
    input  logic [`NOTE_WIDTH-1:0]              note,
    input  logic [`DURATION_WIDTH-1:0]          duration,
    output logic signed [`SAMPLE_WIDTH-1:0]     sample,
    output logic                                active
);

    localparam int TICK_W = $clog2(`BEAT_TICKS);
    localparam int REMAIN_W = `DURATION_WIDTH + TICK_W;
    localparam int HALF_W = `NOTE_WIDTH + 1;
    localparam logic [REMAIN_W-1:0] TICKS_PER_BEAT = REMAIN_W'(`BEAT_TICKS);
    localparam logic [HALF_W-1:0] HALF_BASE = HALF_W'(2 ** `NOTE_WIDTH);
    localparam logic signed [`SAMPLE_WIDTH-1:0] AMP = `AMPLITUDE;

    logic [HALF_W-1:0]     half_len;
    logic [HALF_W-1:0]     half_cnt;
    logic [REMAIN_W-1:0]   remain;
    logic                  polarity;

    // higher note, shorter half period
    always_ff @(posedge clk) begin
        if (load) begin
            half_len <= HALF_BASE - HALF_W'(note);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
            half_cnt <= '0;
            polarity <= 1'b0;
        end else if (load) begin
            // restarts even while playing
            remain <= REMAIN_W'(duration) * TICKS_PER_BEAT;
            half_cnt <= '0;
            polarity <= 1'b1;
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
            if (half_cnt == half_len - 1'b1) begin
                half_cnt <= '0;
                polarity <= ~polarity;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    assign active = (remain != '0);

    // silent once the duration has run out
    always_comb begin
        if (!active) begin
            sample = '0;
        end else if (polarity) begin
            sample = AMP;
        end else begin
            sample = -AMP;
        end
    end

endmodule

/* rtl/sample_mixer.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module sample_mixer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic signed [`SAMPLE_WIDTH-1:0]     sample_a,
    input  logic signed [`SAMPLE_WIDTH-1:0]     sample_b,
    output logic signed [`SAMPLE_WIDTH:0]       mix_out
);

    logic signed [`SAMPLE_WIDTH:0] sum;

    // one extra bit, so the sum cannot overflow
    assign sum = {sample_a[`SAMPLE_WIDTH-1], sample_a}
               + {sample_b[`SAMPLE_WIDTH-1], sample_b};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_out <= '0;
        end else begin
            mix_out <= sum;
        end
    end

endmodule

/* rtl/music_player.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module music_player
    import music_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                play,
    input  logic [1:0]                          song,
    output logic                                song_done,
    output logic signed [`SAMPLE_WIDTH:0]       mix_out,
    output logic                                active_a,
    output logic                                active_b,
    output logic [`NOTE_WIDTH-1:0]              note,
    output logic [`DURATION_WIDTH-1:0]          duration,
    output logic                                load_a,
    output logic                                load_b
);

    logic [`SONG_WIDTH+1:0]              rom_addr;
    logic [`ROM_WORD_WIDTH-1:0]          rom_word;
    logic signed [`SAMPLE_WIDTH-1:0]     sample_a;
    logic signed [`SAMPLE_WIDTH-1:0]     sample_b;
    // reader status, watched from the testbench
    reader_state_e                       reader_state;

    song_rom rom_i (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_word (rom_word)
    );

    song_reader reader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song      (song),
        .rom_word  (rom_word),
        .rom_addr  (rom_addr),
        .note      (note),
        .duration  (duration),
        .load_a    (load_a),
        .load_b    (load_b),
        .song_done (song_done),
        .state     (reader_state)
    );

    // both voices see the same note, only the load differs
    voice_player voice_a_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load_a),
        .note     (note),
        .duration (duration),
        .sample   (sample_a),
        .active   (active_a)
    );

    voice_player voice_b_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load_b),
        .note     (note),
        .duration (duration),
        .sample   (sample_b),
        .active   (active_b)
    );

    sample_mixer mixer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sample_a (sample_a),
        .sample_b (sample_b),
        .mix_out  (mix_out)
    );

endmodule

/* tb/music_player_chk.sv */
`timescale 1ns/1ps

module music_player_chk (
    input logic clk,
    input logic rst_n,
    input logic load_a,
    input logic load_b,
    input logic song_done
);

    // a note entry takes three cycles at the least
    load_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (load_a || load_b) |-> !$past(load_a || load_b) && !$past(load_a || load_b, 2))
        else $error("two loads less than three cycles apart");

    load_a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        load_a |=> !load_a)
        else $error("load_a is high for more than one cycle");

    load_b_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        load_b |=> !load_b)
        else $error("load_b is high for more than one cycle");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        song_done |=> !song_done)
        else $error("song_done is high for more than one cycle");

endmodule

bind song_reader music_player_chk reader_chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_a    (load_a),
    .load_b    (load_b),
    .song_done (song_done)
);

/* tb/music_player_tb.sv */
`timescale 1ns/1ps
`include "music_settings.svh"

module music_player_tb
    import music_pkg::*;
();

    // each high run holds at least 64 cycles, longest entry needs 52 of them
    localparam int SONG_CYCLES = 24 * 3 + 8 * 3 + 15 * `BEAT_TICKS + 1;
    localparam int MAX_RUNS = SONG_CYCLES / 12 + 1;
    localparam int CYCLE_LIMIT = 16 + 4 * MAX_RUNS * (191 + 16) + 200;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            play;
    logic [1:0]                      song;
    logic                            song_done;
    logic signed [`SAMPLE_WIDTH:0]   mix_out;
    logic                            active_a;
    logic                            active_b;
    logic [`NOTE_WIDTH-1:0]          note;
    logic [`DURATION_WIDTH-1:0]      duration;
    logic                            load_a;
    logic                            load_b;

    integer        seed = 32'h0de7b8c8;
    int            cycle_count = 0;
    int            songs_done = 0;
    reader_state_e m_state;
    int            m_index;
    int            m_song;
    int            m_wait_left;
    int            m_mix;
    int            v_k[2];
    int            v_len[2];
    int            v_half[2];

    music_player dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song      (song),
        .song_done (song_done),
        .mix_out   (mix_out),
        .active_a  (active_a),
        .active_b  (active_b),
        .note      (note),
        .duration  (duration),
        .load_a    (load_a),
        .load_b    (load_b)
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic signed [31:0] expected,
                               input logic signed [31:0] actual, input string what);
        if (expected !== actual) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    // song formula
    function automatic int entry_note(int s, int i);
        return ((7 * s + 5 * i) % 62) + 1;
    endfunction

    function automatic int square_level(int k, int len, int half);
        if (k >= len) begin
            return 0;
        end
        return ((k / half) % 2 == 0) ? `AMPLITUDE : -`AMPLITUDE;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timed out after %0d cycles before four songs were played", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // inputs are stable here, outputs have settled
    always @(negedge clk) begin : model_step
        int  sa;
        int  sb;
        int  ld_a;
        int  ld_b;
        int  done_exp;
        bit  note_out;
        if (!rst_n) begin
            m_state = PAUSED;
            m_index = 0;
            m_song = 0;
            m_wait_left = 0;
            m_mix = 0;
            v_k = '{0, 0};
            v_len = '{0, 0};
            v_half = '{1, 1};
        end else begin
            note_out = (m_state == DISPATCH) && play && (m_index % 4 != 3);
            ld_a = note_out && (m_index % 2 == 0);
            ld_b = note_out && (m_index % 2 == 1);
            done_exp = (m_state == ADVANCE) && (m_index == 31);
            check_value(m_state, dut_i.reader_state, "reader state");
            check_value(ld_a, load_a, "load_a");
            check_value(ld_b, load_b, "load_b");
            check_value(done_exp, song_done, "song_done");
            if (note_out) begin
                check_value(entry_note(m_song, m_index), note, "note");
                check_value(m_index % 5 + 1, duration, "duration");
            end
            sa = square_level(v_k[0], v_len[0], v_half[0]);
            sb = square_level(v_k[1], v_len[1], v_half[1]);
            check_value(v_k[0] < v_len[0], active_a, "active_a");
            check_value(v_k[1] < v_len[1], active_b, "active_b");
            check_value(m_mix, mix_out, "mix_out");

            m_mix = sa + sb;
            for (int v = 0; v < 2; v++) begin
                if ((v == 0 && ld_a) || (v == 1 && ld_b)) begin
                    v_k[v] = 0;
                    v_len[v] = (m_index % 5 + 1) * `BEAT_TICKS;
                    v_half[v] = 64 - entry_note(m_song, m_index);
                end else if (v_k[v] < v_len[v]) begin
                    v_k[v]++;
                end
            end
            if (done_exp) begin
                songs_done++;
            end
            case (m_state)
                PAUSED: m_state = play ? RETRIEVE : PAUSED;
                RETRIEVE: begin
                    m_song = song;
                    m_state = play ? DISPATCH : PAUSED;
                end
                DISPATCH: begin
                    if (!play) begin
                        m_state = PAUSED;
                    end else if (m_index % 4 == 3) begin
                        m_wait_left = (m_index % 3 + 1) * `BEAT_TICKS;
                        m_state = WAIT;
                    end else begin
                        m_state = ADVANCE;
                    end
                end
                WAIT: begin
                    if (!play) begin
                        m_state = PAUSED;
                    end else if (m_wait_left == 1) begin
                        m_state = ADVANCE;
                    end else begin
                        m_wait_left--;
                    end
                end
                // the finished entry counts even when play drops here
                ADVANCE: begin
                    m_state = (play && m_index != 31) ? RETRIEVE : PAUSED;
                    m_index = (m_index + 1) % 32;
                end
                default: m_state = PAUSED;
            endcase
        end
    end

    initial begin : stimulus
        int done_before;
        int high_len;
        int low_len;
        rst_n = 1'b0;
        play = 1'b0;
        song = 2'd0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < 4; n++) begin
            done_before = songs_done;
            song <= 2'($random(seed));
            while (songs_done == done_before) begin
                high_len = 64 + ($random(seed) & 127);
                low_len = 1 + ($random(seed) & 15);
                play <= 1'b1;
                for (int c = 0; c < high_len && songs_done == done_before; c++) begin
                    @(posedge clk);
                end
                play <= 1'b0;
                repeat (low_len) @(posedge clk);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
rtl/music_pkg.sv
rtl/song_rom.sv
rtl/song_reader.sv
rtl/voice_player.sv
rtl/sample_mixer.sv
rtl/music_player.sv
tb/music_player_chk.sv
tb/music_player_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module music_player_tb -f sources.f -o music_player_sim
./obj_dir/music_player_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
